//--- design/rmw_pkg.sv
// Read-modify-write package
// Cache geometry and the packed types shared by the store merge path
package rmw_pkg;

   // ##############################
   // Cache geometry
   // ##############################
   parameter int NUM_WAYS   = 8;
   parameter int GROUP_WAYS = 4;
   parameter int LINE_BYTES = 16;
   parameter int BYTE_BITS  = 9;
   parameter int ADDR_W     = 8;
   parameter int LINE_W     = LINE_BYTES * BYTE_BITS;

   // ##############################
   // Basic vectors
   // ##############################
   typedef logic [NUM_WAYS-1:0]   way_vec_t;
   typedef logic [GROUP_WAYS-1:0] grp_vec_t;
   typedef logic [ADDR_W-1:0]     cache_addr_t;
   typedef logic [LINE_BYTES-1:0] byte_en_t;

   // Line bit i belongs to byte i mod LINE_BYTES
   typedef logic [LINE_W-1:0]     line_t;

   // ##############################
   // Pipeline structs
   // ##############################
   typedef struct packed {
      logic        wren;
      way_vec_t    way;
      cache_addr_t addr;
      byte_en_t    bytew;
      line_t       data;
   } stq_wr_req_t;

   typedef struct packed {
      logic        wren;
      way_vec_t    way;
      cache_addr_t addr;
   } stq_stage_t;

   typedef struct packed {
      way_vec_t    way;
      cache_addr_t addr;
      line_t       data_wabcd;
      line_t       data_wefgh;
   } dcarr_wr_t;

   // Load bypass for one four-way group
   typedef struct packed {
      grp_vec_t    stq7_val;
      grp_vec_t    stq_val;
      line_t       stq7_data;
      line_t       stq8_data;
   } ld_byp_t;

endpackage

//--- design/rmw_stage_ctrl.sv
// Store stage control pipeline
// Carries stq5 state into stq6 and stq7 and forms the array write way
module rmw_stage_ctrl import rmw_pkg::*; (
   input  logic        nclk,
   input  logic        rst,
   input  logic        stq5_act,
   input  stq_wr_req_t stq5_req,
   output logic        stq6_act,
   output logic        stq7_act,
   output stq_stage_t  stq6_stage,
   output stq_stage_t  stq7_stage,
   output way_vec_t    wr_way
);

   logic        stq6_wren;
   logic        stq7_wren;
   way_vec_t    stq6_way;
   way_vec_t    stq7_way;
   cache_addr_t stq6_addr;
   cache_addr_t stq7_addr;

   // ##############################
   // Stage activity
   // ##############################
   always_ff @(posedge nclk) begin
      if (rst) begin
         stq6_act <= 1'b0;
         stq7_act <= 1'b0;
      end else begin
         stq6_act <= stq5_act;
         stq7_act <= stq6_act;
      end
   end

   // ##############################
   // Stage state
   // ##############################
   always_ff @(posedge nclk) begin
      if (rst) begin
         stq6_wren <= 1'b0;
         stq7_wren <= 1'b0;
         stq6_way  <= '0;
         stq7_way  <= '0;
         stq6_addr <= '0;
         stq7_addr <= '0;
      end else begin
         // Write enable tracks every cycle
         stq6_wren <= stq5_req.wren;
         stq7_wren <= stq6_wren;

         // Way and address only move with a valid stage
         if (stq5_act) begin
            stq6_way  <= stq5_req.way;
            stq6_addr <= stq5_req.addr;
         end
         if (stq6_act) begin
            stq7_way  <= stq6_way;
            stq7_addr <= stq6_addr;
         end
      end
   end

   assign stq6_stage = '{wren: stq6_wren, way: stq6_way, addr: stq6_addr};
   assign stq7_stage = '{wren: stq7_wren, way: stq7_way, addr: stq7_addr};

   // Single array write way, qualified by stq6 wren
   assign wr_way = {NUM_WAYS{stq6_wren}} & stq6_way;

endmodule

//--- design/rmw_bypass_detect.sv
// Read/write collision logic
// Store correction selects, read activity suppression and load bypass valids
module rmw_bypass_detect import rmw_pkg::*; (
   input  logic        nclk,
   input  logic        rst,
   input  logic        rd_act,
   input  cache_addr_t rd_addr,
   input  way_vec_t    stq5_way,
   input  stq_stage_t  stq6_stage,
   input  stq_stage_t  stq7_stage,
   input  way_vec_t    wr_way,
   output way_vec_t    dcarr_rd_act,
   output logic        stq6_wr_byp_val,
   output logic        stq5_byp_val,
   output grp_vec_t    stq7_val_wabcd,
   output grp_vec_t    stq7_val_wefgh,
   output grp_vec_t    stq_val_wabcd,
   output grp_vec_t    stq_val_wefgh
);

   cache_addr_t ex3_rd_addr;
   logic        ex2_addr_coll;
   way_vec_t    ex2_way_coll;
   logic        stq6_rd_byp_val;
   logic        stq7_rd_byp_val;
   logic        stq7_wr_byp_val;

   // ##############################
   // Read port collision
   // ##############################
   // Ex2 read hitting the line being written this cycle
   assign ex2_addr_coll = (rd_addr == stq6_stage.addr);
   assign ex2_way_coll  = {NUM_WAYS{ex2_addr_coll}} & wr_way;
   assign dcarr_rd_act  = {NUM_WAYS{rd_act}} & ~ex2_way_coll;

   always_ff @(posedge nclk) begin
      if (rst) begin
         ex3_rd_addr <= '0;
      end else begin
         ex3_rd_addr <= rd_addr;
      end
   end

   // ##############################
   // Bypass selects
   // ##############################
   assign stq6_rd_byp_val = (ex3_rd_addr == stq6_stage.addr) & stq6_stage.wren;
   assign stq7_rd_byp_val = (ex3_rd_addr == stq7_stage.addr) & stq7_stage.wren;

   // Store to store only when the stq5 way overlaps the older store
   assign stq6_wr_byp_val = stq6_rd_byp_val & |(stq5_way & stq6_stage.way);
   assign stq7_wr_byp_val = stq7_rd_byp_val & |(stq5_way & stq7_stage.way);
   assign stq5_byp_val    = stq6_wr_byp_val | stq7_wr_byp_val;

   // ##############################
   // Load bypass valids
   // ##############################
   always_ff @(posedge nclk) begin
      if (rst) begin
         stq7_val_wabcd <= '0;
         stq7_val_wefgh <= '0;
         stq_val_wabcd  <= '0;
         stq_val_wefgh  <= '0;
      end else begin
         stq7_val_wabcd <= {GROUP_WAYS{stq6_rd_byp_val}} & stq6_stage.way[GROUP_WAYS-1:0];
         stq7_val_wefgh <= {GROUP_WAYS{stq6_rd_byp_val}} &
                           stq6_stage.way[NUM_WAYS-1:GROUP_WAYS];

         // Either younger stage may hold the line
         stq_val_wabcd <= ({GROUP_WAYS{stq6_rd_byp_val}} & stq6_stage.way[GROUP_WAYS-1:0]) |
                          ({GROUP_WAYS{stq7_rd_byp_val}} & stq7_stage.way[GROUP_WAYS-1:0]);
         stq_val_wefgh <= ({GROUP_WAYS{stq6_rd_byp_val}} &
                           stq6_stage.way[NUM_WAYS-1:GROUP_WAYS]) |
                          ({GROUP_WAYS{stq7_rd_byp_val}} &
                           stq7_stage.way[NUM_WAYS-1:GROUP_WAYS]);
      end
   end

endmodule

//--- design/rmw_way_merge.sv
// Group merge datapath
// Picks the written way's old line, merges new bytes and pipelines the result
module rmw_way_merge import rmw_pkg::*; #(
   parameter int GROUP_WAYS = rmw_pkg::GROUP_WAYS
) (
   input  logic                    nclk,
   input  logic                    rst,
   input  logic                    stq5_act,
   input  logic                    stq6_act,
   input  logic                    stq7_act,
   input  stq_wr_req_t             stq5_req,
   input  logic                    stq5_byp_val,
   input  logic                    stq6_wr_byp_val,
   input  grp_vec_t                grp_way_en,
   input  line_t [GROUP_WAYS-1:0]  grp_rd_data,
   output line_t                   wr_data,
   output line_t                   stq7_data,
   output line_t                   stq8_data
);

   line_t    stq6_rd_line;
   line_t    stq5_wr_bit;
   line_t    stq5_old_line;
   line_t    stq5_byp_line;
   byte_en_t stq5_byte_en;
   byte_en_t stq6_byte_en;
   line_t    stq6_wr_bit;
   line_t    stq6_byp_line;

   // ##############################
   // Old line select
   // ##############################
   // Only the enabled way survives the OR
   always_comb begin
      stq6_rd_line = '0;
      for (int w = 0; w < GROUP_WAYS; w++) begin
         stq6_rd_line = stq6_rd_line | ({LINE_W{grp_way_en[w]}} & grp_rd_data[w]);
      end
   end

   // ##############################
   // Stq5 bypass line
   // ##############################
   // Byte enables fanned out to bits
   assign stq5_wr_bit = {BYTE_BITS{stq5_req.bytew}};

   // Newer merged line wins when stq6 collides
   assign stq5_old_line = stq6_wr_byp_val ? wr_data : stq7_data;
   assign stq5_byp_line = (stq5_wr_bit & stq5_req.data) | (~stq5_wr_bit & stq5_old_line);

   // Whole line comes from the bypass on a correction
   assign stq5_byte_en = stq5_req.bytew | {LINE_BYTES{stq5_byp_val}};

   always_ff @(posedge nclk) begin
      if (rst) begin
         stq6_byte_en  <= '0;
         stq6_byp_line <= '0;
      end else if (stq5_act) begin
         stq6_byte_en  <= stq5_byte_en;
         stq6_byp_line <= stq5_byp_line;
      end
   end

   // ##############################
   // Stq6 merge
   // ##############################
   assign stq6_wr_bit = {BYTE_BITS{stq6_byte_en}};
   assign wr_data     = (stq6_wr_bit & stq6_byp_line) | (~stq6_wr_bit & stq6_rd_line);

   // ##############################
   // Merged line pipeline
   // ##############################
   always_ff @(posedge nclk) begin
      if (rst) begin
         stq7_data <= '0;
      end else if (stq6_act) begin
         stq7_data <= wr_data;
      end
   end

   always_ff @(posedge nclk) begin
      if (rst) begin
         stq8_data <= '0;
      end else if (stq7_act) begin
         stq8_data <= stq7_data;
      end
   end

endmodule

//--- design/lq_rmw_top.sv
// Load/store read-modify-write top
// Joins stage control, collision logic and the two four-way group merges
module lq_rmw_top import rmw_pkg::*; #(
   parameter int NUM_WAYS   = rmw_pkg::NUM_WAYS,
   parameter int GROUP_WAYS = rmw_pkg::GROUP_WAYS
) (
   input  logic                  nclk,
   input  logic                  rst,
   input  logic                  ex2_stq4_rd_act,
   input  cache_addr_t           ex2_stq4_rd_addr,
   input  logic                  stq5_act,
   input  stq_wr_req_t           stq5_req,
   input  line_t [NUM_WAYS-1:0]  stq6_rd_data,
   output way_vec_t              dcarr_rd_act,
   output dcarr_wr_t             dcarr_wr,
   output ld_byp_t               byp_wabcd,
   output ld_byp_t               byp_wefgh
);

   logic       stq6_act;
   logic       stq7_act;
   stq_stage_t stq6_stage;
   stq_stage_t stq7_stage;
   way_vec_t   wr_way;
   logic       stq6_wr_byp_val;
   logic       stq5_byp_val;
   grp_vec_t   stq7_val_wabcd;
   grp_vec_t   stq7_val_wefgh;
   grp_vec_t   stq_val_wabcd;
   grp_vec_t   stq_val_wefgh;
   line_t      wr_data_wabcd;
   line_t      wr_data_wefgh;
   line_t      stq7_data_wabcd;
   line_t      stq7_data_wefgh;
   line_t      stq8_data_wabcd;
   line_t      stq8_data_wefgh;

   // ##############################
   // Control
   // ##############################
   rmw_stage_ctrl u_stage_ctrl (
      .nclk       (nclk),
      .rst        (rst),
      .stq5_act   (stq5_act),
      .stq5_req   (stq5_req),
      .stq6_act   (stq6_act),
      .stq7_act   (stq7_act),
      .stq6_stage (stq6_stage),
      .stq7_stage (stq7_stage),
      .wr_way     (wr_way)
   );

   rmw_bypass_detect u_bypass_detect (
      .nclk            (nclk),
      .rst             (rst),
      .rd_act          (ex2_stq4_rd_act),
      .rd_addr         (ex2_stq4_rd_addr),
      .stq5_way        (stq5_req.way),
      .stq6_stage      (stq6_stage),
      .stq7_stage      (stq7_stage),
      .wr_way          (wr_way),
      .dcarr_rd_act    (dcarr_rd_act),
      .stq6_wr_byp_val (stq6_wr_byp_val),
      .stq5_byp_val    (stq5_byp_val),
      .stq7_val_wabcd  (stq7_val_wabcd),
      .stq7_val_wefgh  (stq7_val_wefgh),
      .stq_val_wabcd   (stq_val_wabcd),
      .stq_val_wefgh   (stq_val_wefgh)
   );

   // ##############################
   // Group merges
   // ##############################
   // Ways A to D
   rmw_way_merge #(
      .GROUP_WAYS (GROUP_WAYS)
   ) u_merge_wabcd (
      .nclk            (nclk),
      .rst             (rst),
      .stq5_act        (stq5_act),
      .stq6_act        (stq6_act),
      .stq7_act        (stq7_act),
      .stq5_req        (stq5_req),
      .stq5_byp_val    (stq5_byp_val),
      .stq6_wr_byp_val (stq6_wr_byp_val),
      .grp_way_en      (stq6_stage.way[GROUP_WAYS-1:0]),
      .grp_rd_data     (stq6_rd_data[GROUP_WAYS-1:0]),
      .wr_data         (wr_data_wabcd),
      .stq7_data       (stq7_data_wabcd),
      .stq8_data       (stq8_data_wabcd)
   );

   // Ways E to H
   rmw_way_merge #(
      .GROUP_WAYS (GROUP_WAYS)
   ) u_merge_wefgh (
      .nclk            (nclk),
      .rst             (rst),
      .stq5_act        (stq5_act),
      .stq6_act        (stq6_act),
      .stq7_act        (stq7_act),
      .stq5_req        (stq5_req),
      .stq5_byp_val    (stq5_byp_val),
      .stq6_wr_byp_val (stq6_wr_byp_val),
      .grp_way_en      (stq6_stage.way[NUM_WAYS-1:GROUP_WAYS]),
      .grp_rd_data     (stq6_rd_data[NUM_WAYS-1:GROUP_WAYS]),
      .wr_data         (wr_data_wefgh),
      .stq7_data       (stq7_data_wefgh),
      .stq8_data       (stq8_data_wefgh)
   );

   // ##############################
   // Outputs
   // ##############################
   assign dcarr_wr = '{way: wr_way, addr: stq6_stage.addr,
                       data_wabcd: wr_data_wabcd, data_wefgh: wr_data_wefgh};

   assign byp_wabcd = '{stq7_val: stq7_val_wabcd, stq_val: stq_val_wabcd,
                        stq7_data: stq7_data_wabcd, stq8_data: stq8_data_wabcd};
   assign byp_wefgh = '{stq7_val: stq7_val_wefgh, stq_val: stq_val_wefgh,
                        stq7_data: stq7_data_wefgh, stq8_data: stq8_data_wefgh};

endmodule

//--- dv/lq_rmw_checker.sv
// Read-modify-write assertions
// Array write way shape and read hold-off on the line being written
module lq_rmw_checker import rmw_pkg::*; (
   input logic        nclk,
   input logic        rst,
   input logic        stq5_act,
   input stq_wr_req_t stq5_req,
   input cache_addr_t rd_addr,
   input way_vec_t    dcarr_rd_act,
   input dcarr_wr_t   dcarr_wr
);

   // At most one way written per cycle
   wr_way_onehot: assert property (@(posedge nclk) disable iff (rst)
      $onehot0(dcarr_wr.way))
      else $error("array write way has more than one bit set");

   wr_way_after_rst: assert property (@(posedge nclk)
      rst |=> (dcarr_wr.way == '0))
      else $error("array write way not zero after reset");

   // A store taken at stq5 last cycle holds off reads of its way and line now
   rd_wr_excl: assert property (@(posedge nclk) disable iff (rst)
      (!$past(rst) && $past(stq5_act && stq5_req.wren) &&
       (rd_addr == $past(stq5_req.addr))) |->
      ((dcarr_rd_act & $past(stq5_req.way)) == '0))
      else $error("read activity on the way being written at the same address");

endmodule

//--- dv/lq_rmw_tb.sv
// Read-modify-write testbench
// LFSR store stream checked against a reference array and byte merge
module lq_rmw_tb import rmw_pkg::*; ();

   typedef struct packed {
      logic        act;
      logic        rd;
      logic [2:0]  wix;
      cache_addr_t addr;
      byte_en_t    bytew;
      line_t       data;
   } slot_t;

   logic                 nclk;
   logic                 rst;
   logic                 ex2_stq4_rd_act;
   cache_addr_t          ex2_stq4_rd_addr;
   logic                 stq5_act;
   stq_wr_req_t          stq5_req;
   line_t [NUM_WAYS-1:0] stq6_rd_data;
   way_vec_t             dcarr_rd_act;
   dcarr_wr_t            dcarr_wr;
   ld_byp_t              byp_wabcd;
   ld_byp_t              byp_wefgh;

   logic [31:0]          lfsr = 32'hb877;
   line_t                arr [NUM_WAYS][256];
   line_t [NUM_WAYS-1:0] snap [4];
   slot_t                slots [$];
   string                names [$];
   line_t                exp_line [];
   cache_addr_t          addr_pool [4] = '{8'h10, 8'h4c, 8'h93, 8'he7};
   string                cur_test = "reset";
   logic                 chk_en = 1'b0;
   int                   cmp_count = 0;

   // Expected values for the current cycle
   way_vec_t             exp_rd_act;
   way_vec_t             exp_way;
   cache_addr_t          exp_addr;
   line_t                exp_data;
   way_vec_t             exp_s7v;
   way_vec_t             exp_sv;
   logic                 s7_chk = 1'b0;
   logic                 s8_chk = 1'b0;
   logic                 s7_grp;
   logic                 s8_grp;
   line_t                exp_s7data;
   line_t                exp_s8data;

   lq_rmw_top #(
      .NUM_WAYS   (NUM_WAYS),
      .GROUP_WAYS (GROUP_WAYS)
   ) UUT (
      .nclk             (nclk),
      .rst              (rst),
      .ex2_stq4_rd_act  (ex2_stq4_rd_act),
      .ex2_stq4_rd_addr (ex2_stq4_rd_addr),
      .stq5_act         (stq5_act),
      .stq5_req         (stq5_req),
      .stq6_rd_data     (stq6_rd_data),
      .dcarr_rd_act     (dcarr_rd_act),
      .dcarr_wr         (dcarr_wr),
      .byp_wabcd        (byp_wabcd),
      .byp_wefgh        (byp_wefgh)
   );

   bind lq_rmw_top lq_rmw_checker u_checker (
      .nclk         (nclk),
      .rst          (rst),
      .stq5_act     (stq5_act),
      .stq5_req     (stq5_req),
      .rd_addr      (ex2_stq4_rd_addr),
      .dcarr_rd_act (dcarr_rd_act),
      .dcarr_wr     (dcarr_wr)
   );

   initial begin
      nclk = 1'b0;
      forever #20 nclk = ~nclk;
   end

   // ##############################
   // Reference helpers
   // ##############################
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
   endfunction

   // One LFSR step per bit taken
   function automatic line_t rand_bits(input int n);
      line_t r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         r[i] = lfsr[0];
      end
      return r;
   endfunction

   // Bit i takes the new value when byte i mod 16 is enabled
   function automatic line_t merge_line(input line_t old_line, input byte_en_t bytew,
                                        input line_t new_line);
      line_t r;
      for (int i = 0; i < LINE_W; i++) begin
         r[i] = bytew[i % LINE_BYTES] ? new_line[i] : old_line[i];
      end
      return r;
   endfunction

   function automatic slot_t slot_at(input int k);
      if (k < 0 || k >= slots.size()) return '0;
      return slots[k];
   endfunction

   function automatic way_vec_t way_of(input slot_t s);
      return s.act ? (way_vec_t'(1) << s.wix) : '0;
   endfunction

   // Ways of a writing store whose line matches a read address
   function automatic way_vec_t hit_way(input slot_t s, input cache_addr_t a);
      return (s.addr == a) ? way_of(s) : '0;
   endfunction

   task automatic add_store(input string name, input logic [2:0] wix, input cache_addr_t addr);
      slot_t s;
      s.act = 1'b1;
      s.rd = 1'b1;
      s.wix = wix;
      s.addr = addr;
      s.bytew = byte_en_t'(rand_bits(LINE_BYTES));
      s.data = rand_bits(LINE_W);
      slots.push_back(s);
      names.push_back(name);
   endtask

   task automatic add_idle(input string name, input logic rd, input cache_addr_t addr);
      slot_t s;
      s = '0;
      s.rd = rd;
      s.addr = addr;
      slots.push_back(s);
      names.push_back(name);
   endtask

   task automatic check(input string what, input line_t exp_v, input line_t act_v);
      if (exp_v !== act_v) begin
         $display("[ERROR] %s %s: expected %0h actual %0h", cur_test, what, exp_v, act_v);
         $display("Result: FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   // ##############################
   // Stimulus
   // ##############################
   initial begin
      slot_t l4;
      slot_t l5;
      slot_t l6;
      slot_t l7;
      slot_t l8;
      int    tmo;

      rst = 1'b1;
      ex2_stq4_rd_act = 1'b1;
      ex2_stq4_rd_addr = '0;
      stq5_act = 1'b0;
      stq5_req = '0;
      stq6_rd_data = '0;
      for (int w = 0; w < NUM_WAYS; w++) begin
         for (int a = 0; a < 256; a++) begin
            arr[w][a] = {18{8'(a) ^ 8'(w * 29)}};
         end
      end
      for (int i = 0; i < 4; i++) begin
         snap[i] = '0;
      end

      add_idle("startup", 1'b0, 8'h00);
      add_idle("startup", 1'b0, 8'h00);
      add_store("single_store", 3'd2, 8'h21);
      add_idle("single_store", 1'b0, 8'h00);
      add_idle("single_store", 1'b0, 8'h00);
      add_store("same_line_gap1", 3'd5, 8'h35);
      add_store("same_line_gap1", 3'd5, 8'h35);
      add_idle("same_line_gap1", 1'b0, 8'h00);
      add_idle("same_line_gap1", 1'b0, 8'h00);
      // Middle read hits the first store while it sits in stq6
      add_store("same_line_gap2", 3'd1, 8'h47);
      add_idle("same_line_gap2", 1'b1, 8'h47);
      add_store("same_line_gap2", 3'd1, 8'h47);
      add_idle("same_line_gap2", 1'b0, 8'h00);
      add_idle("same_line_gap2", 1'b0, 8'h00);
      add_store("load_bypass", 3'd6, 8'h58);
      add_idle("load_bypass", 1'b1, 8'h58);
      add_idle("load_bypass", 1'b1, 8'h58);
      add_idle("load_bypass", 1'b0, 8'h00);
      for (int i = 0; i < 300; i++) begin
         if (rand_bits(2) == '0) begin
            add_idle("random_stream", 1'(rand_bits(1)), addr_pool[2'(rand_bits(2))]);
         end
         add_store("random_stream", 3'(rand_bits(3)), addr_pool[2'(rand_bits(2))]);
      end
      for (int i = 0; i < 4; i++) begin
         add_idle("drain", 1'b0, 8'h00);
      end
      exp_line = new[slots.size()];

      repeat (5) @(posedge nclk);
      rst <= 1'b0;
      @(negedge nclk);
      check("wr_way", '0, dcarr_wr.way);
      check("stq7_val", '0, {byp_wefgh.stq7_val, byp_wabcd.stq7_val});
      check("stq_val", '0, {byp_wefgh.stq_val, byp_wabcd.stq_val});
      check("rd_act", {NUM_WAYS{1'b1}}, dcarr_rd_act);

      for (int n = 0; n < slots.size(); n++) begin
         @(posedge nclk);
         l4 = slot_at(n + 1);
         l5 = slot_at(n);
         l6 = slot_at(n - 1);
         l7 = slot_at(n - 2);
         l8 = slot_at(n - 3);

         // Write seen last cycle lands in the array at this edge
         if (l7.act) arr[l7.wix][l7.addr] = exp_line[n - 2];
         if (l6.act) exp_line[n - 1] = merge_line(arr[l6.wix][l6.addr], l6.bytew, l6.data);
         for (int w = 0; w < NUM_WAYS; w++) begin
            snap[(n + 1) % 4][w] = arr[w][l4.addr];
         end

         ex2_stq4_rd_act <= l4.rd;
         ex2_stq4_rd_addr <= l4.addr;
         stq5_act <= l5.act;
         stq5_req <= '{wren: l5.act, way: way_of(l5), addr: l5.addr,
                       bytew: l5.bytew, data: l5.data};
         stq6_rd_data <= snap[(n + 3) % 4];

         cur_test = names[(n > 0) ? n - 1 : 0];
         exp_rd_act = {NUM_WAYS{l4.rd}} & ~hit_way(l6, l4.addr);
         exp_way = way_of(l6);
         exp_addr = l6.addr;
         if (l6.act) exp_data = exp_line[n - 1];

         // Ex3 of the last cycle against its stq6 and stq7
         s8_chk = s7_chk;
         s8_grp = s7_grp;
         exp_s8data = exp_s7data;
         exp_s7v = hit_way(l7, l6.addr);
         exp_sv = exp_s7v | hit_way(l8, l6.addr);
         s7_chk = (exp_s7v != '0);
         s7_grp = l7.wix[2];
         if (s7_chk) exp_s7data = exp_line[n - 2];
         chk_en = 1'b1;
      end

      tmo = 0;
      while (cmp_count < slots.size() && tmo < 10) begin
         @(posedge nclk);
         tmo++;
      end
      chk_en = 1'b0;
      if (cmp_count < slots.size()) begin
         $display("Timeout: compare process checked %0d of %0d cycles", cmp_count,
                  slots.size());
         $display("Result: FAILED");
         $fatal(1, "compare timeout");
      end else begin
         $display("Result: PASSED");
         $finish;
      end
   end

   // ##############################
   // Compare
   // ##############################
   always @(negedge nclk) begin
      if (chk_en) begin
         check("rd_act", exp_rd_act, dcarr_rd_act);
         check("wr_way", exp_way, dcarr_wr.way);
         if (exp_way != '0) begin
            check("wr_addr", exp_addr, dcarr_wr.addr);
            check("wr_data", exp_data, (exp_way[GROUP_WAYS-1:0] != '0) ?
                  dcarr_wr.data_wabcd : dcarr_wr.data_wefgh);
         end
         check("stq7_val", exp_s7v, {byp_wefgh.stq7_val, byp_wabcd.stq7_val});
         check("stq_val", exp_sv, {byp_wefgh.stq_val, byp_wabcd.stq_val});
         if (s7_chk) begin
            check("stq7_data", exp_s7data, s7_grp ? byp_wefgh.stq7_data : byp_wabcd.stq7_data);
         end
         if (s8_chk) begin
            check("stq8_data", exp_s8data, s8_grp ? byp_wefgh.stq8_data : byp_wabcd.stq8_data);
         end
         cmp_count++;
      end
   end

endmodule

//--- filelist.f
design/rmw_pkg.sv
design/rmw_stage_ctrl.sv
design/rmw_bypass_detect.sv
design/rmw_way_merge.sv
design/lq_rmw_top.sv
dv/lq_rmw_checker.sv
dv/lq_rmw_tb.sv

//--- Bender.yml
package:
  name: lq_rmw

sources:
  - design/rmw_pkg.sv
  - design/rmw_stage_ctrl.sv
  - design/rmw_bypass_detect.sv
  - design/rmw_way_merge.sv
  - design/lq_rmw_top.sv
  - target: test
    files:
      - dv/lq_rmw_checker.sv
      - dv/lq_rmw_tb.sv
